/* Bender.yml */
package:
  name: sad_trigger

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sad_pkg.sv
      - hdl/sad_regs.sv
      - hdl/sad_window_seq.sv
      - hdl/sad_accum_bank.sv
      - hdl/sad_trigger_ctrl.sv
      - hdl/sad_trigger_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_sad_trigger.sv

/* flist.f */
+incdir+hdl
hdl/sad_pkg.sv
hdl/sad_regs.sv
hdl/sad_window_seq.sv
hdl/sad_accum_bank.sv
hdl/sad_trigger_ctrl.sv
hdl/sad_trigger_top.sv
tb/tb_clock_gen.sv
tb/tb_sad_trigger.sv

/* hdl/sad_accum_bank.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module sad_accum_bank (
    input  logic                         adc_sampleclk,
    input  logic                         reset,
    input  sad_pkg::sample_t             adc_datain,
    input  sad_pkg::ref_bank_t           ref_bank,
    input  sad_pkg::refen_t              refen,
    input  sad_pkg::sad_t                threshold,
    input  sad_pkg::slot_t               slot,
    input  logic [`SAD_REF_SAMPLES-1:0]  restart,
    input  logic [`SAD_REF_SAMPLES-1:0]  report,
    output logic [`SAD_REF_SAMPLES-1:0]  slot_match
);
    import sad_pkg::*;

    localparam int N = `SAD_REF_SAMPLES;
    localparam int W = `SAD_BITS_PER_SAMPLE;
    localparam int MSB = `SAD_COUNTER_WIDTH - 1;

    sample_t adc_r;
    sample_t adc_r2;  // lines up with the per-slot reference lookup

    always_ff @(posedge adc_sampleclk) begin
        adc_r <= adc_datain;
        adc_r2 <= adc_r;
    end

    for (genvar k = 0; k < N; k++) begin : g_acc
        slot_t   pos;
        sample_t ref_r;
        logic    en_r;
        sample_t incr;
        sad_t    sum;
        logic    match;

        // position of adc_r within this accumulator's window
        assign pos = (slot >= k) ? slot_t'(slot - k) : slot_t'(slot + N - k);

        always_ff @(posedge adc_sampleclk) begin
            ref_r <= ref_bank[pos*W +: W];
            en_r <= refen[pos];

            if (!en_r)
                incr <= '0;  // masked position
            else if (adc_r2 > ref_r)
                incr <= adc_r2 - ref_r;
            else
                incr <= ref_r - adc_r2;

            if (restart[k])
                sum <= sad_t'(incr);
            else if (!sum[MSB])  // stick once saturated
                sum <= sum + sad_t'(incr);
        end

        // sum is complete in the cycle the accumulator restarts
        always_ff @(posedge adc_sampleclk) begin
            if (reset)
                match <= 1'b0;
            else
                match <= report[k] && (sum <= threshold);
        end

        assign slot_match[k] = match;
    end

endmodule

/* hdl/sad_cfg.svh */
`ifndef SAD_CFG_SVH
`define SAD_CFG_SVH

// window and datapath sizes
`define SAD_REF_SAMPLES      32
`define SAD_BITS_PER_SAMPLE  8
`define SAD_COUNTER_WIDTH    16  // accumulator width, msb flags saturation
`define SAD_BYTECNT_SIZE     7

// last window sample registered to trigger, in cycles
`define SAD_TRIGGER_LATENCY  5

// design code in the top two bits of the version register
`define SAD_VERSION_CODE     2'b01

// register map
`define SAD_REG_REFERENCE          8'h40
`define SAD_REG_REFEN              8'h41
`define SAD_REG_THRESHOLD          8'h42
`define SAD_REG_STATUS             8'h43  // write of any data clears
`define SAD_REG_BITS_PER_SAMPLE    8'h44
`define SAD_REG_REF_SAMPLES        8'h45
`define SAD_REG_COUNTER_WIDTH      8'h46
`define SAD_REG_MULTIPLE_TRIGGERS  8'h47
`define SAD_REG_VERSION            8'h48
`define SAD_REG_ALWAYS_ARMED       8'h49

`endif

/* hdl/sad_pkg.sv */
`include "sad_cfg.svh"

package sad_pkg;

    typedef logic [`SAD_BITS_PER_SAMPLE-1:0] sample_t;
    typedef logic [`SAD_COUNTER_WIDTH-1:0] sad_t;  // sums and threshold
    typedef logic [`SAD_REF_SAMPLES-1:0] refen_t;

    // position 0 sits in the low byte
    typedef logic [`SAD_REF_SAMPLES*`SAD_BITS_PER_SAMPLE-1:0] ref_bank_t;

    typedef logic [$clog2(`SAD_REF_SAMPLES)-1:0] slot_t;
    typedef logic [7:0] reg_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,  // first window still filling
        RUN
    } sad_phase_t;

    typedef struct packed {
        sad_t   threshold;
        refen_t refen;
        logic   multiple_triggers;
        logic   always_armed;
    } sad_config_t;

    typedef struct packed {
        logic [15:0] num_triggers;
        logic        triggered;
    } sad_status_t;

endpackage

/* hdl/sad_regs.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module sad_regs (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  sad_pkg::reg_addr_t            reg_address,
    input  logic [`SAD_BYTECNT_SIZE-1:0]  reg_bytecnt,
    input  logic [7:0]                    reg_datai,
    output logic [7:0]                    reg_datao,
    input  logic                          reg_read,
    input  logic                          reg_write,
    input  sad_pkg::sad_status_t          status,
    output sad_pkg::sad_config_t          cfg,
    output sad_pkg::ref_bank_t            ref_bank,
    output logic                          clear_pulse
);
    import sad_pkg::*;

    localparam int REF_BYTES = `SAD_REF_SAMPLES * `SAD_BITS_PER_SAMPLE / 8;
    localparam int REFEN_BYTES = `SAD_REF_SAMPLES / 8;
    localparam int THR_BYTES = `SAD_COUNTER_WIDTH / 8;

    logic [31:0] status_word;
    logic [7:0]  version_byte;

    assign status_word = {8'b0, status.num_triggers, 7'b0, status.triggered};
    assign version_byte = {2'(`SAD_VERSION_CODE), 6'(`SAD_TRIGGER_LATENCY)};

    // one byte lane of a 32-bit word, zero past the top
    function automatic logic [7:0] lane_byte(input logic [31:0] word,
                                             input logic [`SAD_BYTECNT_SIZE-1:0] lane);
        logic [7:0] b;
        b = 8'h00;
        if (lane < 4)
            b = word[lane*8 +: 8];
        return b;
    endfunction

    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                `SAD_REG_REFERENCE: begin
                    if (reg_bytecnt < REF_BYTES)
                        reg_datao = ref_bank[reg_bytecnt*8 +: 8];
                end
                `SAD_REG_REFEN:             reg_datao = lane_byte(cfg.refen, reg_bytecnt);
                `SAD_REG_THRESHOLD:         reg_datao = lane_byte(32'(cfg.threshold), reg_bytecnt);
                `SAD_REG_STATUS:            reg_datao = lane_byte(status_word, reg_bytecnt);
                `SAD_REG_BITS_PER_SAMPLE:   reg_datao = 8'(`SAD_BITS_PER_SAMPLE);
                `SAD_REG_REF_SAMPLES:       reg_datao = lane_byte(32'(`SAD_REF_SAMPLES), reg_bytecnt);
                `SAD_REG_COUNTER_WIDTH:     reg_datao = 8'(`SAD_COUNTER_WIDTH);
                `SAD_REG_MULTIPLE_TRIGGERS: reg_datao = {7'b0, cfg.multiple_triggers};
                `SAD_REG_VERSION:           reg_datao = version_byte;
                `SAD_REG_ALWAYS_ARMED:      reg_datao = {7'b0, cfg.always_armed};
                default:                    reg_datao = 8'h00;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_bank <= '0;
            cfg <= '{threshold: '0, refen: '1, multiple_triggers: 1'b0, always_armed: 1'b0};
            clear_pulse <= 1'b0;
        end else begin
            clear_pulse <= reg_write && (reg_address == `SAD_REG_STATUS);
            if (reg_write) begin
                case (reg_address)
                    `SAD_REG_REFERENCE: begin
                        if (reg_bytecnt < REF_BYTES)
                            ref_bank[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    `SAD_REG_REFEN: begin
                        if (reg_bytecnt < REFEN_BYTES)
                            cfg.refen[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    `SAD_REG_THRESHOLD: begin
                        if (reg_bytecnt < THR_BYTES)  // upper lanes read back as zero
                            cfg.threshold[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    `SAD_REG_MULTIPLE_TRIGGERS: cfg.multiple_triggers <= reg_datai[0];
                    `SAD_REG_ALWAYS_ARMED:      cfg.always_armed <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // host side never issues both strobes in one cycle
    a_no_read_write: assert property (
        @(posedge adc_sampleclk) disable iff (reset) !(reg_read && reg_write)
    );

endmodule

/* hdl/sad_trigger_ctrl.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module sad_trigger_ctrl (
    input  logic                         adc_sampleclk,
    input  logic                         reset,
    input  logic [`SAD_REF_SAMPLES-1:0]  slot_match,
    input  logic                         multiple_triggers,
    input  logic                         clear_pulse,
    input  logic                         arm_pulse,
    output logic                         trigger,
    output sad_pkg::sad_status_t         status
);
    import sad_pkg::*;

    logic lockout;    // single-trigger mode already fired
    logic trigger_q;

    assign lockout = status.triggered && !multiple_triggers;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger <= 1'b0;
            trigger_q <= 1'b0;
            status <= '0;
        end else begin
            trigger <= (|slot_match) && !lockout;
            trigger_q <= trigger;

            if (clear_pulse || arm_pulse) begin
                status <= '0;
            end else if (trigger && !trigger_q) begin
                // count rising edges, back-to-back matches count once
                status.triggered <= 1'b1;
                status.num_triggers <= status.num_triggers + 1'b1;
            end
        end
    end

    a_lockout: assert property (
        @(posedge adc_sampleclk) disable iff (reset) lockout |=> !trigger
    );

endmodule

/* hdl/sad_trigger_top.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module sad_trigger_top (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  sad_pkg::sample_t              adc_datain,
    input  logic                          armed_and_ready,
    input  logic                          active,
    input  logic                          xadc_error,
    input  sad_pkg::reg_addr_t            reg_address,
    input  logic [`SAD_BYTECNT_SIZE-1:0]  reg_bytecnt,
    input  logic [7:0]                    reg_datai,
    output logic [7:0]                    reg_datao,
    input  logic                          reg_read,
    input  logic                          reg_write,
    output logic                          trigger
);
    import sad_pkg::*;

    sad_config_t                  cfg;
    sad_status_t                  status;
    ref_bank_t                    ref_bank;
    logic                         clear_pulse;
    logic                         arm_pulse;
    slot_t                        slot;
    logic [`SAD_REF_SAMPLES-1:0]  restart;
    logic [`SAD_REF_SAMPLES-1:0]  report;
    logic [`SAD_REF_SAMPLES-1:0]  slot_match;

    sad_regs sad_regs_inst (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .reg_datai     (reg_datai),
        .reg_datao     (reg_datao),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .status        (status),
        .cfg           (cfg),
        .ref_bank      (ref_bank),
        .clear_pulse   (clear_pulse)
    );

    sad_window_seq sad_window_seq_inst (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .always_armed    (cfg.always_armed),
        .slot            (slot),
        .restart         (restart),
        .report          (report),
        .arm_pulse       (arm_pulse)
    );

    sad_accum_bank sad_accum_bank_inst (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_datain    (adc_datain),
        .ref_bank      (ref_bank),
        .refen         (cfg.refen),
        .threshold     (cfg.threshold),
        .slot          (slot),
        .restart       (restart),
        .report        (report),
        .slot_match    (slot_match)
    );

    sad_trigger_ctrl sad_trigger_ctrl_inst (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .slot_match        (slot_match),
        .multiple_triggers (cfg.multiple_triggers),
        .clear_pulse       (clear_pulse),
        .arm_pulse         (arm_pulse),
        .trigger           (trigger),
        .status            (status)
    );

endmodule

/* hdl/sad_window_seq.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module sad_window_seq (
    input  logic                         adc_sampleclk,
    input  logic                         reset,
    input  logic                         armed_and_ready,
    input  logic                         active,
    input  logic                         xadc_error,
    input  logic                         always_armed,
    output sad_pkg::slot_t               slot,
    output logic [`SAD_REF_SAMPLES-1:0]  restart,
    output logic [`SAD_REF_SAMPLES-1:0]  report,
    output logic                         arm_pulse
);
    import sad_pkg::*;

    localparam int N = `SAD_REF_SAMPLES;
    localparam slot_t LAST_SLOT = slot_t'(N - 1);

    // restart lags slot by the two-stage lookup in the bank,
    // so the token for accumulator 0 starts two places back
    localparam logic [N-1:0] FIRST_RESTART = N'(1) << (N - 2);

    logic       enable;
    sad_phase_t phase;
    logic [1:0] run_dly;  // RUN delayed to line up with restart

    assign enable = (armed_and_ready || always_armed) && active && !xadc_error;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            phase <= IDLE;
            slot <= '0;
            restart <= '0;
            run_dly <= '0;
            arm_pulse <= 1'b0;
        end else begin
            arm_pulse <= enable && (phase == IDLE);
            if (!enable) begin
                phase <= IDLE;
                slot <= '0;
                restart <= '0;
                run_dly <= '0;
            end else if (phase == IDLE) begin
                phase <= FILL;
                slot <= '0;  // first enabled sample is index 0
                restart <= FIRST_RESTART;
                run_dly <= '0;
            end else begin
                slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
                restart <= {restart[N-2:0], restart[N-1]};
                run_dly <= {run_dly[0], phase == RUN};
                if (phase == FILL && slot == LAST_SLOT)
                    phase <= RUN;
            end
        end
    end

    // run_dly is cleared whenever the phase leaves RUN, so this is RUN-gated
    assign report = restart & {N{run_dly[1]}};

    // the staggered bank needs exactly one accumulator restarting per cycle
    a_one_restart: assert property (
        @(posedge adc_sampleclk) disable iff (reset) (phase != IDLE) |-> $onehot(restart)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic adc_sampleclk,
    output logic reset
);
    initial begin
        adc_sampleclk = 1'b0;
        forever #5 adc_sampleclk = ~adc_sampleclk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge adc_sampleclk);
        reset <= 1'b0;
    end
endmodule

/* tb/tb_sad_trigger.sv */
`timescale 1ns/1ns
`include "sad_cfg.svh"

module tb_sad_trigger;
    import sad_pkg::*;

    localparam int N = `SAD_REF_SAMPLES;
    localparam int RUN_CYCLES = 300 + 400 + 500 + 600 + 600;  // rough budget per test

    logic adc_sampleclk, reset, armed_and_ready, active, xadc_error;
    logic reg_read, reg_write, trigger;
    sample_t adc_datain;
    reg_addr_t reg_address;
    logic [`SAD_BYTECNT_SIZE-1:0] reg_bytecnt;
    logic [7:0] reg_datai, reg_datao, exp_rd;
    logic [31:0] lfsr = 32'he2d1b216;
    int trig_errors = 0;
    int read_errors = 0;
    string test_name = "reset";

    // model state, mirrors the register writes seen on the bus
    sample_t hist[$];
    sample_t m_ref[N];
    refen_t m_refen;
    sad_t m_thr;
    logic m_mt, m_aa, m_enabled, m_triggered, clear_p, arm_p;
    logic [15:0] m_count;
    logic [4:0] mdly;  // window done, delayed toward trigger
    logic exp_trigger, exp_trig_q;

    tb_clock_gen clk_gen (.adc_sampleclk(adc_sampleclk), .reset(reset));

    sad_trigger_top sad_trigger_top_inst (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int window_sad();
        int sum;
        int d;
        sum = 0;
        for (int i = 0; i < N; i++) begin
            d = int'(hist[i]) - int'(m_ref[i]);  // oldest sample is position 0
            if (d < 0) d = -d;
            if (m_refen[i] && sum < (1 << (`SAD_COUNTER_WIDTH - 1)))
                sum += d;
        end
        return sum;
    endfunction

    always @(posedge adc_sampleclk) begin
        logic en_now;
        logic done;
        if (reset) begin
            hist.delete();
            m_refen <= '1;
            m_thr <= '0;
            m_mt <= 1'b0;
            m_aa <= 1'b0;
            m_enabled <= 1'b0;
            m_triggered <= 1'b0;
            m_count <= '0;
            clear_p <= 1'b0;
            arm_p <= 1'b0;
            mdly <= '0;
            exp_trigger <= 1'b0;
            exp_trig_q <= 1'b0;
            foreach (m_ref[i]) m_ref[i] <= '0;
        end else begin
            en_now = (armed_and_ready || m_aa) && active && !xadc_error;
            done = 1'b0;
            if (en_now) begin
                hist.push_back(adc_datain);
                if (hist.size() > N) void'(hist.pop_front());
                if (hist.size() == N) done = (window_sad() <= int'(m_thr));
            end else begin
                hist.delete();
            end
            mdly <= {mdly[3:0], done};
            exp_trigger <= mdly[4] && !(m_triggered && !m_mt);
            exp_trig_q <= exp_trigger;
            clear_p <= reg_write && (reg_address == `SAD_REG_STATUS);
            arm_p <= en_now && !m_enabled;
            m_enabled <= en_now;
            if (clear_p || arm_p) begin
                m_triggered <= 1'b0;
                m_count <= '0;
            end else if (exp_trigger && !exp_trig_q) begin
                m_triggered <= 1'b1;
                m_count <= m_count + 1'b1;
            end
            if (reg_write) begin
                case (reg_address)
                    `SAD_REG_REFERENCE: if (reg_bytecnt < N) m_ref[reg_bytecnt] <= reg_datai;
                    `SAD_REG_REFEN: if (reg_bytecnt < 4) m_refen[reg_bytecnt*8 +: 8] <= reg_datai;
                    `SAD_REG_THRESHOLD: if (reg_bytecnt < 2) m_thr[reg_bytecnt*8 +: 8] <= reg_datai;
                    `SAD_REG_MULTIPLE_TRIGGERS: m_mt <= reg_datai[0];
                    `SAD_REG_ALWAYS_ARMED: m_aa <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    a_trigger: assert property (@(posedge adc_sampleclk) disable iff (reset)
        trigger == exp_trigger)
    else begin
        trig_errors++;
        $display("** Error [%s] trigger expected %0b actual %0b",
                 test_name, $sampled(exp_trigger), $sampled(trigger));
    end

    // idle port reads as zero
    a_readback: assert property (@(posedge adc_sampleclk) disable iff (reset)
        reg_datao == (reg_read ? exp_rd : 8'h00))
    else begin
        read_errors++;
        $display("** Error [%s] reg_datao expected %02h actual %02h",
                 test_name, $sampled(reg_read) ? $sampled(exp_rd) : 8'h00,
                 $sampled(reg_datao));
    end

    task automatic write_reg(input reg_addr_t addr, input int lane, input logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= lane;
        reg_datai <= data;
        reg_write <= 1'b1;
        @(posedge adc_sampleclk);
        reg_write <= 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input int lane, input logic [7:0] exp);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= lane;
        reg_read <= 1'b1;
        exp_rd <= exp;
        @(posedge adc_sampleclk);
        reg_read <= 1'b0;
    endtask

    function automatic logic [7:0] random_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stream_random(input int n);
        repeat (n) begin
            @(posedge adc_sampleclk);
            adc_datain <= random_byte();
        end
    endtask

    // reference window, one position optionally offset
    task automatic send_pattern(input int bad_pos, input logic [7:0] delta);
        for (int i = 0; i < N; i++) begin
            @(posedge adc_sampleclk);
            adc_datain <= (i == bad_pos) ? m_ref[i] + delta : m_ref[i];
        end
        stream_random(12);  // drain the pipeline
    endtask

    task automatic check_status();
        read_check(`SAD_REG_STATUS, 0, {7'b0, m_triggered});
        read_check(`SAD_REG_STATUS, 1, m_count[7:0]);
    endtask

    initial begin
        {armed_and_ready, active, xadc_error, reg_read, reg_write} = '0;
        adc_datain = '0;
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai = '0;
        exp_rd = '0;
        wait (!reset);
        test_name = "register readback";
        for (int i = 0; i < N; i++) write_reg(`SAD_REG_REFERENCE, i, random_byte());
        for (int i = 0; i < N; i++) read_check(`SAD_REG_REFERENCE, i, m_ref[i]);
        write_reg(`SAD_REG_REFEN, 2, 8'ha5);
        read_check(`SAD_REG_REFEN, 2, 8'ha5);
        write_reg(`SAD_REG_REFEN, 2, 8'hff);
        write_reg(`SAD_REG_THRESHOLD, 1, 8'h3c);
        read_check(`SAD_REG_THRESHOLD, 1, 8'h3c);
        write_reg(`SAD_REG_THRESHOLD, 1, 8'h00);
        write_reg(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        write_reg(`SAD_REG_ALWAYS_ARMED, 0, 8'h01);
        read_check(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        read_check(`SAD_REG_ALWAYS_ARMED, 0, 8'h01);
        write_reg(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        write_reg(`SAD_REG_ALWAYS_ARMED, 0, 8'h00);
        read_check(`SAD_REG_BITS_PER_SAMPLE, 0, 8'd8);
        read_check(`SAD_REG_REF_SAMPLES, 0, 8'd32);
        read_check(`SAD_REG_COUNTER_WIDTH, 0, 8'd16);
        read_check(`SAD_REG_VERSION, 0, {2'b01, 6'd5});

        test_name = "matching";
        armed_and_ready <= 1'b1;
        active <= 1'b1;
        stream_random(40);
        send_pattern(-1, 0);
        stream_random(120);  // random data, no match expected
        check_status();

        test_name = "mask and threshold";
        write_reg(`SAD_REG_STATUS, 0, 8'h00);
        write_reg(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        write_reg(`SAD_REG_REFEN, 0, 8'hf0);
        send_pattern(2, 8'd77);  // masked position
        write_reg(`SAD_REG_THRESHOLD, 0, 8'd20);
        stream_random(40);
        send_pattern(10, 8'd15);
        stream_random(40);
        send_pattern(10, 8'd40);
        write_reg(`SAD_REG_THRESHOLD, 0, 8'd0);
        write_reg(`SAD_REG_REFEN, 0, 8'hff);
        check_status();

        test_name = "lockout and count";
        write_reg(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        write_reg(`SAD_REG_STATUS, 0, 8'h00);
        repeat (3) begin
            stream_random(40);
            send_pattern(-1, 0);
        end
        check_status();
        write_reg(`SAD_REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        write_reg(`SAD_REG_STATUS, 0, 8'h00);
        repeat (3) begin
            stream_random(40);
            send_pattern(-1, 0);
        end
        check_status();

        test_name = "clear and gating";
        armed_and_ready <= 1'b0;
        stream_random(5);
        armed_and_ready <= 1'b1;  // new arm clears the status
        stream_random(5);
        check_status();
        active <= 1'b0;
        send_pattern(-1, 0);
        active <= 1'b1;
        xadc_error <= 1'b1;
        stream_random(40);
        send_pattern(-1, 0);
        xadc_error <= 1'b0;
        armed_and_ready <= 1'b0;
        write_reg(`SAD_REG_ALWAYS_ARMED, 0, 8'h01);
        stream_random(40);
        send_pattern(-1, 0);
        check_status();

        $display("errors: %0d trigger, %0d readback", trig_errors, read_errors);
        if (trig_errors == 0 && read_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 2 * 10);
        $display("watchdog expired before the tests completed");
        $display("errors: %0d trigger, %0d readback", trig_errors, read_errors);
        $display("Testbench failed");
        $finish;
    end
endmodule
